/* lvds_tx.f */
rtl/lvds_tx_pkg.sv
rtl/lvds_delay_if.sv
rtl/lvds_tx_formatter.sv
rtl/lvds_delay_ctrl.sv
rtl/lvds_tx_delay_line.sv
rtl/lvds_ddr_out.sv
rtl/lvds_tx_top.sv
verif/tb_clk_gen.sv
verif/lvds_tx_tb.sv

/* rtl/lvds_ddr_out.sv */
// behavioral model of the ddr output cell, one per channel

module lvds_ddr_out (
  input  logic                                                tx_clk,
  input  logic                                                rst,
  input  lvds_tx_pkg::bit_pair_t [lvds_tx_pkg::NUM_CHAN-1:0]  pairs,
  output logic [lvds_tx_pkg::NUM_CHAN-1:0]                    tx_data_out_p,
  output logic [lvds_tx_pkg::NUM_CHAN-1:0]                    tx_data_out_n
);

  import lvds_tx_pkg::*;

  // both halves captured together on the rising edge
  bit_pair_t [NUM_CHAN-1:0] pair_q;

  always_ff @(posedge tx_clk) begin
    if (rst) begin
      pair_q <= '0;
    end else begin
      pair_q <= pairs;
    end
  end

  // **************************************************
  // pin drive
  // **************************************************

  // p half in the high phase, n half in the low phase
  always_comb begin
    for (int c = 0; c < NUM_CHAN; c++) begin
      tx_data_out_p[c] = tx_clk ? pair_q[c].p : pair_q[c].n;
    end
  end

  // differential partner
  assign tx_data_out_n = ~tx_data_out_p;

endmodule

/* rtl/lvds_delay_ctrl.sv */
module lvds_delay_ctrl #(
  parameter int LOCK_CYCLES = 16
) (
  input  logic                                             tx_clk,
  input  logic                                             rst,
  input  logic                                             delay_rst,
  input  logic [lvds_tx_pkg::NUM_CHAN-1:0]                 up_dld,
  input  lvds_tx_pkg::tap_t [lvds_tx_pkg::NUM_CHAN-1:0]    up_dwdata,
  output lvds_tx_pkg::tap_t [lvds_tx_pkg::NUM_CHAN-1:0]    up_drdata,
  output logic                                             delay_locked,
  lvds_delay_if.ctrl                                       dly
);

  import lvds_tx_pkg::*;

  localparam int CNT_W = $clog2(LOCK_CYCLES + 1);

  logic [CNT_W-1:0] lock_cnt;

  // **************************************************
  // lock counter
  // **************************************************

  // counts edges since the last reset, stops once locked
  always_ff @(posedge tx_clk) begin
    if (rst || delay_rst) begin
      lock_cnt     <= '0;
      delay_locked <= 1'b0;
    end else if (!delay_locked) begin
      lock_cnt <= lock_cnt + 1'b1;
      if (lock_cnt == CNT_W'(LOCK_CYCLES - 1)) begin
        delay_locked <= 1'b1;
      end
    end
  end

  // tap loads are dropped until the block is locked
  assign dly.ld     = up_dld & {NUM_CHAN{delay_locked}};
  assign dly.wdata  = up_dwdata;
  assign dly.locked = delay_locked;

  // readback comes straight from the lane tap registers
  assign up_drdata = dly.rdata;

  // lock rises LOCK_CYCLES edges after the last edge that saw a reset
  a_lock_delay : assert property (
    @(posedge tx_clk)
    $rose(delay_locked) |-> $past(rst || delay_rst, LOCK_CYCLES + 1)
  ) else $error("delay_locked rose at the wrong time after reset");

endmodule

/* rtl/lvds_delay_if.sv */
// tap load and readback path between delay control and the lanes

interface lvds_delay_if;

  import lvds_tx_pkg::*;

  // one-cycle load strobe per channel, already gated by lock
  logic [NUM_CHAN-1:0] ld;

  // new tap values, taken when the matching ld bit is set
  tap_t [NUM_CHAN-1:0] wdata;

  // taps currently in use by each delay line
  tap_t [NUM_CHAN-1:0] rdata;

  // level, high once the delay block has settled
  logic locked;

  // control side owns strobes and lock
  modport ctrl (
    output ld,
    output wdata,
    output locked,
    input  rdata
  );

  // lane side holds the taps
  modport lane (
    input  ld,
    input  wdata,
    input  locked,
    output rdata
  );

endinterface

/* rtl/lvds_tx_delay_line.sv */
module lvds_tx_delay_line (
  input  logic                                                tx_clk,
  input  logic                                                rst,
  input  lvds_tx_pkg::bit_pair_t [lvds_tx_pkg::NUM_CHAN-1:0]  pairs_in,
  output lvds_tx_pkg::bit_pair_t [lvds_tx_pkg::NUM_CHAN-1:0]  pairs_out,
  lvds_delay_if.lane                                          dly
);

  import lvds_tx_pkg::*;

  // input itself counts as stage 0, so 32 selectable positions
  localparam int DEPTH = 2 ** TAP_WIDTH;

  // current tap per channel
  tap_t [NUM_CHAN-1:0] tap_q;

  // stage i holds the input from i cycles ago
  bit_pair_t shreg [NUM_CHAN][1:DEPTH-1];

  // **************************************************
  // tap registers
  // **************************************************

  always_ff @(posedge tx_clk) begin
    if (rst) begin
      tap_q <= '0;
    end else begin
      for (int c = 0; c < NUM_CHAN; c++) begin
        // ld is gated upstream, lock checked again here
        if (dly.ld[c] && dly.locked) begin
          tap_q[c] <= dly.wdata[c];
        end
      end
    end
  end

  assign dly.rdata = tap_q;

  // **************************************************
  // whole-cycle delay lines
  // **************************************************

  // stage 1 takes the input, each later stage its predecessor
  always_ff @(posedge tx_clk) begin
    for (int c = 0; c < NUM_CHAN; c++) begin
      if (rst) begin
        for (int i = 1; i < DEPTH; i++) begin
          shreg[c][i] <= '0;
        end
      end else begin
        shreg[c][1] <= pairs_in[c];
        for (int i = 2; i < DEPTH; i++) begin
          shreg[c][i] <= shreg[c][i-1];
        end
      end
    end
  end

  // tap 0 bypasses the line, any other tap picks its stage
  always_comb begin
    for (int c = 0; c < NUM_CHAN; c++) begin
      if (tap_q[c] == '0) begin
        pairs_out[c] = pairs_in[c];
      end else begin
        pairs_out[c] = shreg[c][tap_q[c]];
      end
    end
  end

endmodule

/* rtl/lvds_tx_formatter.sv */
module lvds_tx_formatter (
  input  logic                                                tx_clk,
  input  logic                                                rst,
  input  logic                                                dac_valid,
  input  logic [lvds_tx_pkg::SAMPLE_WIDTH-1:0]                dac_data,
  output lvds_tx_pkg::bit_pair_t [lvds_tx_pkg::NUM_CHAN-1:0]  pairs
);

  import lvds_tx_pkg::*;

  typedef bit_pair_t [NUM_CHAN-1:0] chan_pairs_t;

  // high while the second half of a sample is due
  logic phase;

  // low byte waits here for the second cycle
  logic [7:0] low_hold;

  // **************************************************
  // byte to lane mapping
  // **************************************************

  // lane k gets bit 2k+1 on p and bit 2k on n
  // frame lane marks which half of the sample is on the wire
  function automatic chan_pairs_t map_byte(input logic [7:0] b, input logic frame);
    chan_pairs_t res;
    res = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      res[k].p = b[2*k+1];
      res[k].n = b[2*k];
    end
    res[NUM_CHAN-1].p = frame;
    res[NUM_CHAN-1].n = frame;
    return res;
  endfunction

  // **************************************************
  // two-cycle sequencer
  // **************************************************

  always_ff @(posedge tx_clk) begin
    if (rst) begin
      phase <= 1'b0;
      pairs <= '0;
    end else if (phase) begin
      // second cycle carries the low byte with frame low
      phase <= 1'b0;
      pairs <= map_byte(low_hold, 1'b0);
    end else if (dac_valid) begin
      // first cycle carries the high byte with frame high
      phase <= 1'b1;
      pairs <= map_byte(dac_data[SAMPLE_WIDTH-1:8], 1'b1);
    end else begin
      // idle lanes sit at zero
      pairs <= '0;
    end
  end

  // low byte captured together with the accepted sample
  always_ff @(posedge tx_clk) begin
    if (!phase && dac_valid) begin
      low_hold <= dac_data[7:0];
    end
  end

  // a sample occupies two cycles, so valid can't come twice in a row
  a_valid_rate : assert property (
    @(posedge tx_clk) disable iff (rst)
    dac_valid |=> !dac_valid
  ) else $error("dac_valid asserted on consecutive cycles");

endmodule

/* rtl/lvds_tx_pkg.sv */
// **************************************************
// sizes of the dac transmit path
// **************************************************

package lvds_tx_pkg;

  // one dac sample per valid strobe
  localparam int SAMPLE_WIDTH = 16;

  // each lane carries two bits per cycle, two cycles per sample
  localparam int NUM_LANES = SAMPLE_WIDTH / 4;

  // data lanes plus the frame lane on top
  localparam int NUM_CHAN = NUM_LANES + 1;

  // delay tap range is 0 .. 2**TAP_WIDTH-1 cycles
  localparam int TAP_WIDTH = 5;

  // **************************************************
  // types
  // **************************************************

  typedef logic [TAP_WIDTH-1:0] tap_t;

  // p goes out while tx_clk is high, n while it is low
  typedef struct packed {
    logic p;
    logic n;
  } bit_pair_t;

endpackage

/* rtl/lvds_tx_top.sv */
module lvds_tx_top #(
  parameter int LOCK_CYCLES = 16
) (
  // dac sample input
  input  logic                                             tx_clk,
  input  logic                                             rst,
  input  logic                                             dac_valid,
  input  logic [lvds_tx_pkg::SAMPLE_WIDTH-1:0]             dac_data,

  // lvds pins
  output logic [lvds_tx_pkg::NUM_CHAN-1:0]                 tx_data_out_p,
  output logic [lvds_tx_pkg::NUM_CHAN-1:0]                 tx_data_out_n,

  // tap access
  input  logic [lvds_tx_pkg::NUM_CHAN-1:0]                 up_dld,
  input  lvds_tx_pkg::tap_t [lvds_tx_pkg::NUM_CHAN-1:0]    up_dwdata,
  output lvds_tx_pkg::tap_t [lvds_tx_pkg::NUM_CHAN-1:0]    up_drdata,

  // delay control
  input  logic                                             delay_rst,
  output logic                                             delay_locked
);

  import lvds_tx_pkg::*;

  // formatter to delay line
  bit_pair_t [NUM_CHAN-1:0] fmt_pairs;
  // delay line to output cells
  bit_pair_t [NUM_CHAN-1:0] dly_pairs;

  lvds_delay_if dly_if ();

  lvds_tx_formatter i_formatter (
    .tx_clk    (tx_clk),
    .rst       (rst),
    .dac_valid (dac_valid),
    .dac_data  (dac_data),
    .pairs     (fmt_pairs)
  );

  lvds_delay_ctrl #(
    .LOCK_CYCLES (LOCK_CYCLES)
  ) i_delay_ctrl (
    .tx_clk       (tx_clk),
    .rst          (rst),
    .delay_rst    (delay_rst),
    .up_dld       (up_dld),
    .up_dwdata    (up_dwdata),
    .up_drdata    (up_drdata),
    .delay_locked (delay_locked),
    .dly          (dly_if.ctrl)
  );

  lvds_tx_delay_line i_delay_line (
    .tx_clk    (tx_clk),
    .rst       (rst),
    .pairs_in  (fmt_pairs),
    .pairs_out (dly_pairs),
    .dly       (dly_if.lane)
  );

  lvds_ddr_out i_ddr_out (
    .tx_clk        (tx_clk),
    .rst           (rst),
    .pairs         (dly_pairs),
    .tx_data_out_p (tx_data_out_p),
    .tx_data_out_n (tx_data_out_n)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module lvds_tx_tb \
  -f lvds_tx.f \
  -o lvds_tx_sim

# the testbench stops on its first error, so keep going and judge by the log
./obj_dir/lvds_tx_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "Test passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

/* verif/lvds_tx_tb.sv */
module lvds_tx_tb;

  import lvds_tx_pkg::*;

  localparam int LOCK_CYCLES    = 16;
  localparam int NUM_ROWS       = 8;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + 100;
  // room for outputs scheduled up to 34 cycles past the last edge
  localparam int EXP_DEPTH      = TIMEOUT_CYCLES + 40;

  // one stimulus row with sample, random flag, load flag and taps
  typedef struct packed {
    logic [SAMPLE_WIDTH-1:0] sample;
    logic                    use_rand;
    logic                    load;
    tap_t [NUM_CHAN-1:0]     taps;
  } row_t;

  logic                     clk;
  logic                     rst;
  logic                     dac_valid;
  logic [SAMPLE_WIDTH-1:0]  dac_data;
  logic [NUM_CHAN-1:0]      tx_data_out_p;
  logic [NUM_CHAN-1:0]      tx_data_out_n;
  logic [NUM_CHAN-1:0]      up_dld;
  tap_t [NUM_CHAN-1:0]      up_dwdata;
  tap_t [NUM_CHAN-1:0]      up_drdata;
  logic                     delay_rst;
  logic                     delay_locked;

  row_t                     rows [NUM_ROWS];
  tap_t [NUM_CHAN-1:0]      cur_taps;
  // expected rising-half and falling-half bits, per period after edge e
  logic [NUM_CHAN-1:0]      want_p [EXP_DEPTH];
  logic [NUM_CHAN-1:0]      want_n [EXP_DEPTH];
  int                       cyc = 0;

  tb_clk_gen #(.PERIOD(40)) clk_gen (.clk(clk));

  lvds_tx_top #(
    .LOCK_CYCLES (LOCK_CYCLES)
  ) lvds_tx_top_inst (
    .tx_clk        (clk),
    .rst           (rst),
    .dac_valid     (dac_valid),
    .dac_data      (dac_data),
    .tx_data_out_p (tx_data_out_p),
    .tx_data_out_n (tx_data_out_n),
    .up_dld        (up_dld),
    .up_dwdata     (up_dwdata),
    .up_drdata     (up_drdata),
    .delay_rst     (delay_rst),
    .delay_locked  (delay_locked)
  );

  // **************************************************
  // reporting
  // **************************************************

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_bits(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else
      fail_now($sformatf("ERR %s got 0x%h expected 0x%h at cycle %0d", name, got, want, cyc));
  endtask

  // **************************************************
  // reference model
  // **************************************************

  // {p, n} of one channel with half 0 the high byte and the frame lane 11 then 00
  function automatic logic [1:0] lane_pair(input logic [15:0] s, input int half, input int c);
    logic [7:0] b;
    if (c == NUM_CHAN - 1) begin
      return (half == 0) ? 2'b11 : 2'b00;
    end
    b = (half == 0) ? s[15:8] : s[7:0];
    return {b[2*c+1], b[2*c]};
  endfunction

  // sample driven at edge t shows up in the periods after t+2+d and t+3+d
  task automatic record_sample(input int t, input logic [15:0] s);
    logic [1:0] pr;
    for (int c = 0; c < NUM_CHAN; c++) begin
      for (int h = 0; h < 2; h++) begin
        pr = lane_pair(s, h, c);
        want_p[t+2+h+int'(cur_taps[c])][c] = pr[1];
        want_n[t+2+h+int'(cur_taps[c])][c] = pr[0];
      end
    end
  endtask

  // **************************************************
  // cycle counter, timeout and pin monitor
  // **************************************************

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      fail_now($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // p half checked mid high phase, n half mid low phase
  always @(posedge clk) begin
    logic [NUM_CHAN-1:0] inv;
    #10;
    if (cyc >= 1) begin
      inv = ~want_p[cyc];
      check_bits("tx_data_out_p", tx_data_out_p, want_p[cyc]);
      check_bits("tx_data_out_n", tx_data_out_n, inv);
    end
    #20;
    if (cyc >= 1) begin
      inv = ~want_n[cyc];
      check_bits("tx_data_out_p", tx_data_out_p, want_n[cyc]);
      check_bits("tx_data_out_n", tx_data_out_n, inv);
    end
  end

  // **************************************************
  // stimulus tasks
  // **************************************************

  // called on the last edge that sees the reset high
  // a load is tried while unlocked and must not land
  task automatic release_and_check_lock(input bit full_reset);
    if (full_reset) begin
      rst <= 1'b0;
    end else begin
      delay_rst <= 1'b0;
    end
    #10;
    check_bits("delay_locked", delay_locked, 0);
    for (int i = 1; i <= LOCK_CYCLES; i++) begin
      @(posedge clk);
      if (i == 2) begin
        up_dld    <= '1;
        up_dwdata <= {NUM_CHAN{TAP_WIDTH'(9)}};
      end
      if (i == 3) begin
        up_dld <= '0;
      end
      #10;
      check_bits("delay_locked", delay_locked, (i == LOCK_CYCLES));
      check_bits("up_drdata", up_drdata, cur_taps);
    end
  endtask

  // drain the pipe first so no sample straddles a tap change
  task automatic load_taps(input tap_t [NUM_CHAN-1:0] taps);
    repeat (40) @(posedge clk);
    up_dld    <= '1;
    up_dwdata <= taps;
    #10;
    check_bits("up_drdata", up_drdata, cur_taps);
    @(posedge clk);
    up_dld <= '0;
    #10;
    check_bits("up_drdata", up_drdata, taps);
    cur_taps = taps;
  endtask

  task automatic send_sample(input logic [15:0] s);
    @(posedge clk);
    dac_valid <= 1'b1;
    dac_data  <= s;
    // counter has not yet moved at this edge
    record_sample(cyc + 1, s);
    @(posedge clk);
    dac_valid <= 1'b0;
  endtask

  // frame lane taps come first in each concatenation
  task automatic build_table;
    rows[0] = '{sample: 16'hA5C3, use_rand: 1'b0, load: 1'b0, taps: '0};
    rows[1] = '{sample: 16'h0000, use_rand: 1'b1, load: 1'b0, taps: '0};
    rows[2] = '{sample: 16'h1234, use_rand: 1'b0, load: 1'b0, taps: '0};
    rows[3] = '{sample: 16'hFF00, use_rand: 1'b0, load: 1'b1,
                taps: {5'd3, 5'd0, 5'd5, 5'd2, 5'd1}};
    rows[4] = '{sample: 16'h0000, use_rand: 1'b1, load: 1'b0, taps: '0};
    rows[5] = '{sample: 16'h8001, use_rand: 1'b0, load: 1'b1,
                taps: {5'd31, 5'd7, 5'd0, 5'd12, 5'd4}};
    rows[6] = '{sample: 16'h0000, use_rand: 1'b1, load: 1'b0, taps: '0};
    rows[7] = '{sample: 16'h5A5A, use_rand: 1'b0, load: 1'b1, taps: '0};
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (rows[r].use_rand) begin
        rows[r].sample = 16'($urandom());
      end
    end
  endtask

  // **************************************************
  // main sequence
  // **************************************************

  initial begin
    void'($urandom(20));
    rst       = 1'b1;
    dac_valid = 1'b0;
    dac_data  = '0;
    up_dld    = '0;
    up_dwdata = '0;
    delay_rst = 1'b0;
    cur_taps  = '0;
    for (int i = 0; i < EXP_DEPTH; i++) begin
      want_p[i] = '0;
      want_n[i] = '0;
    end
    build_table();

    repeat (10) @(posedge clk);
    release_and_check_lock(1'b1);

    // delay_rst pulse relocks on its own
    @(posedge clk);
    delay_rst <= 1'b1;
    @(posedge clk);
    release_and_check_lock(1'b0);

    // rows without a load follow at the full rate
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (rows[r].load) begin
        load_taps(rows[r].taps);
      end
      send_sample(rows[r].sample);
    end
    repeat (40) @(posedge clk);

    $display("Test passed");
    $finish;
  end

endmodule

/* verif/tb_clk_gen.sv */
// free-running clock for the testbench

module tb_clk_gen #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  // starts low, first rising edge half a period in
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule
